/* include/hist_consts.svh */
`ifndef HIST_CONSTS_SVH
`define HIST_CONSTS_SVH

// frame dimensions
// hits per pixel in one acquisition
`define DATA_NUM 4
// pixels per acquisition
`define PIXEL_NUM 4
// acquisitions per frame
`define ACQ_NUM 3

// index widths for the frame counters
`define NB_PIXEL 2
`define NB_HIT 2
`define NB_ACQ 2

// bin address widths, 16 coarse and 8 fine bins
`define NB_COARSE 4
`define NB_FINE 3

// count widths, both hold DATA_NUM * ACQ_NUM hits
`define CW_COARSE 8
`define CW_FINE 6

`endif

/* hdl/hist_pkg.sv */
`default_nettype none

`include "hist_consts.svh"

package hist_pkg;

    // frame indices
    typedef logic [`NB_PIXEL-1:0] pixel_t;
    typedef logic [`NB_HIT-1:0] hit_idx_t;
    typedef logic [`NB_ACQ-1:0] acq_t;

    // bin addresses
    typedef logic [`NB_COARSE-1:0] coarse_bin_t;
    typedef logic [`NB_FINE-1:0] fine_bin_t;

    // per-bin hit counts
    typedef logic [`CW_COARSE-1:0] coarse_count_t;
    typedef logic [`CW_FINE-1:0] fine_count_t;

    // frame sequencing
    // IDLE waits for start, ACCUM and FINAL take hits,
    // DONE is the one-cycle frame end
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ACCUM = 2'd1,
        FINAL = 2'd2,
        DONE  = 2'd3
    } frame_state_t;

endpackage

`default_nettype wire

/* hdl/hist_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_consts.svh"

module hist_fsm (
    input  wire  clk,
    input  wire  combin_res,
    input  wire  start,
    input  wire  hit,
    input  wire  acq_end,
    output logic accept,
    output logic clear,
    output logic fresh,
    output logic report_en,
    output logic frame_done,
    output logic bank
);

    import hist_pkg::*;

    // single-acquisition frames skip ACCUM
    localparam frame_state_t START_STATE = (`ACQ_NUM == 1) ? FINAL : ACCUM;
    // index of the reporting acquisition
    localparam acq_t ACQ_LAST = acq_t'(`ACQ_NUM - 1);

    frame_state_t state;
    acq_t acq_cnt;
    acq_t acq_next;
    logic step;

    // hits only count while the frame is open
    assign accept = (state == ACCUM) || (state == FINAL);
    assign step = hit && accept;

    // start is honoured in IDLE only
    assign clear = start && (state == IDLE);

    assign fresh = (acq_cnt == '0);
    assign report_en = (state == FINAL);
    assign frame_done = (state == DONE);

    assign acq_next = acq_cnt + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= IDLE;
            acq_cnt <= '0;
            bank <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        acq_cnt <= '0;
                        state <= START_STATE;
                    end
                end
                ACCUM: begin
                    // last hit of an acquisition
                    if (step && acq_end) begin
                        acq_cnt <= acq_next;
                        // next acquisition reports peaks
                        if (acq_next == ACQ_LAST) begin
                            state <= FINAL;
                        end
                    end
                end
                FINAL: begin
                    // last hit of the frame
                    if (step && acq_end) begin
                        acq_cnt <= '0;
                        state <= DONE;
                    end
                end
                DONE: begin
                    // swap to the other bank for the next frame
                    bank <= ~bank;
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_consts.svh"

module frame_counter (
    input  wire             clk,
    input  wire             combin_res,
    input  wire             clear,
    input  wire             step,
    output hist_pkg::pixel_t pixel,
    output logic            pixel_first,
    output logic            pixel_last,
    output logic            acq_end
);

    import hist_pkg::*;

    // wrap points of the two counters
    localparam hit_idx_t HIT_LAST = hit_idx_t'(`DATA_NUM - 1);
    localparam pixel_t PIXEL_LAST = pixel_t'(`PIXEL_NUM - 1);

    hit_idx_t hit_idx;
    logic last_pixel;

    // flags follow the hit index of the current hit
    assign pixel_first = (hit_idx == '0);
    assign pixel_last = (hit_idx == HIT_LAST);

    assign last_pixel = (pixel == PIXEL_LAST);

    // final hit of the final pixel closes the acquisition
    assign acq_end = pixel_last && last_pixel;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_idx <= '0;
            pixel <= '0;
        end else if (clear) begin
            // frame start
            hit_idx <= '0;
            pixel <= '0;
        end else if (step) begin
            if (pixel_last) begin
                hit_idx <= '0;
                // pixel index wraps at the end of an acquisition
                if (last_pixel) begin
                    pixel <= '0;
                end else begin
                    pixel <= pixel + 1'b1;
                end
            end else begin
                hit_idx <= hit_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/bin_histogram.sv */
`timescale 1ns/1ps
`default_nettype none

module bin_histogram #(
    parameter type count_t = logic [7:0],
    parameter int  NB = 4
) (
    input  wire              clk,
    input  wire              combin_res,
    input  wire              clear,
    input  wire              bank,
    input  wire              step,
    input  wire hist_pkg::pixel_t pixel,
    input  wire [NB-1:0]     bin,
    output count_t           count,
    output logic             count_valid
);

    import hist_pkg::*;

    // word address inside one bank is pixel then bin
    localparam int WA = $bits(pixel_t) + NB;
    localparam int WORDS = 2 ** WA;

    // two banks of counts, one valid bit per word
    count_t mem [2][WORDS];
    logic [WORDS-1:0] valid [2];

    logic [WA-1:0] waddr;
    // bank and word of the last update
    logic [WA:0] last_addr;
    logic fwd;
    count_t old_count;
    logic old_valid;
    count_t new_count;

    assign waddr = {pixel, bin};

    // bypass the word written in the previous cycle
    assign fwd = count_valid && (last_addr == {bank, waddr});

    always_comb begin
        if (fwd) begin
            old_count = count;
            old_valid = 1'b1;
        end else begin
            old_count = mem[bank][waddr];
            old_valid = valid[bank][waddr];
        end
        // stale word from an older frame counts as empty
        if (old_valid) begin
            new_count = old_count + 1'b1;
        end else begin
            new_count = count_t'(1);
        end
    end

    // valid bits and output strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid[0] <= '0;
            valid[1] <= '0;
            count_valid <= 1'b0;
        end else begin
            count_valid <= step;
            if (clear) begin
                // whole bank emptied in one cycle
                valid[bank] <= '0;
            end else if (step) begin
                valid[bank][waddr] <= 1'b1;
            end
        end
    end

    // count storage and registered result
    always_ff @(posedge clk) begin
        if (step) begin
            mem[bank][waddr] <= new_count;
            count <= new_count;
            last_addr <= {bank, waddr};
        end
    end

endmodule

`default_nettype wire

/* hdl/peak_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_consts.svh"

module peak_tracker #(
    parameter type count_t = logic [7:0],
    parameter int  NB = 4
) (
    input  wire              clk,
    input  wire              combin_res,
    input  wire              step,
    input  wire              fresh,
    input  wire              report_en,
    input  wire hist_pkg::pixel_t pixel,
    input  wire [NB-1:0]     bin,
    input  wire              pixel_first,
    input  wire              pixel_last,
    input  wire count_t      count,
    input  wire              count_valid,
    output logic             peak_valid,
    output hist_pkg::pixel_t peak_pixel,
    output logic [NB-1:0]    peak_bin
);

    import hist_pkg::*;

    // running maximum and its bin, per pixel
    count_t run_max [`PIXEL_NUM];
    logic [NB-1:0] run_bin [`PIXEL_NUM];

    // hit context delayed to line up with count
    pixel_t pixel_d;
    logic [NB-1:0] bin_d;
    logic first_d;
    logic report_d;

    logic take;
    logic [NB-1:0] best_bin;

    // first hit of the frame for this pixel restarts the maximum
    // strictly greater keeps the earliest bin on ties
    assign take = first_d || (count > run_max[pixel_d]);
    assign best_bin = take ? bin_d : run_bin[pixel_d];

    // flags
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            first_d <= 1'b0;
            report_d <= 1'b0;
            peak_valid <= 1'b0;
        end else begin
            first_d <= step && fresh && pixel_first;
            report_d <= step && report_en && pixel_last;
            // one report per pixel in the final acquisition
            peak_valid <= count_valid && report_d;
        end
    end

    // hit context for the histogram latency
    always_ff @(posedge clk) begin
        if (step) begin
            pixel_d <= pixel;
            bin_d <= bin;
        end
    end

    // running maximum update
    always_ff @(posedge clk) begin
        if (count_valid && take) begin
            run_max[pixel_d] <= count;
            run_bin[pixel_d] <= bin_d;
        end
    end

    // peak report includes the pixel's last hit
    always_ff @(posedge clk) begin
        if (count_valid && report_d) begin
            peak_pixel <= pixel_d;
            peak_bin <= best_bin;
        end
    end

endmodule

`default_nettype wire

/* hdl/hist_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_consts.svh"

module hist_top (
    input  wire                      clk,
    input  wire                      combin_res,
    input  wire                      start,
    input  wire                      hit,
    input  wire hist_pkg::coarse_bin_t coarse_bin,
    input  wire hist_pkg::fine_bin_t   fine_bin,
    output logic                     accept,
    output logic                     his_num,
    output logic                     frame_done,
    output logic                     coarse_peak_valid,
    output hist_pkg::pixel_t         coarse_peak_pixel,
    output hist_pkg::coarse_bin_t    coarse_peak_bin,
    output logic                     fine_peak_valid,
    output hist_pkg::pixel_t         fine_peak_pixel,
    output hist_pkg::fine_bin_t      fine_peak_bin
);

    import hist_pkg::*;

    // accepted hit
    wire step = hit & accept;

    logic clear;
    logic fresh;
    logic report_en;
    logic acq_end;
    pixel_t pixel;
    logic pixel_first;
    logic pixel_last;

    // histogram results
    coarse_count_t coarse_count;
    logic coarse_count_valid;
    fine_count_t fine_count;
    logic fine_count_valid;

    hist_fsm i_fsm (
        .clk        (clk),
        .combin_res (combin_res),
        .start      (start),
        .hit        (hit),
        .acq_end    (acq_end),
        .accept     (accept),
        .clear      (clear),
        .fresh      (fresh),
        .report_en  (report_en),
        .frame_done (frame_done),
        .bank       (his_num)
    );

    frame_counter i_counter (
        .clk         (clk),
        .combin_res  (combin_res),
        .clear       (clear),
        .step        (step),
        .pixel       (pixel),
        .pixel_first (pixel_first),
        .pixel_last  (pixel_last),
        .acq_end     (acq_end)
    );

    // coarse path
    bin_histogram #(.count_t(coarse_count_t), .NB(`NB_COARSE)) i_coarse_hist (
        .clk         (clk),
        .combin_res  (combin_res),
        .clear       (clear),
        .bank        (his_num),
        .step        (step),
        .pixel       (pixel),
        .bin         (coarse_bin),
        .count       (coarse_count),
        .count_valid (coarse_count_valid)
    );

    peak_tracker #(.count_t(coarse_count_t), .NB(`NB_COARSE)) i_coarse_peak (
        .clk         (clk),
        .combin_res  (combin_res),
        .step        (step),
        .fresh       (fresh),
        .report_en   (report_en),
        .pixel       (pixel),
        .bin         (coarse_bin),
        .pixel_first (pixel_first),
        .pixel_last  (pixel_last),
        .count       (coarse_count),
        .count_valid (coarse_count_valid),
        .peak_valid  (coarse_peak_valid),
        .peak_pixel  (coarse_peak_pixel),
        .peak_bin    (coarse_peak_bin)
    );

    // fine path
    bin_histogram #(.count_t(fine_count_t), .NB(`NB_FINE)) i_fine_hist (
        .clk         (clk),
        .combin_res  (combin_res),
        .clear       (clear),
        .bank        (his_num),
        .step        (step),
        .pixel       (pixel),
        .bin         (fine_bin),
        .count       (fine_count),
        .count_valid (fine_count_valid)
    );

    peak_tracker #(.count_t(fine_count_t), .NB(`NB_FINE)) i_fine_peak (
        .clk         (clk),
        .combin_res  (combin_res),
        .step        (step),
        .fresh       (fresh),
        .report_en   (report_en),
        .pixel       (pixel),
        .bin         (fine_bin),
        .pixel_first (pixel_first),
        .pixel_last  (pixel_last),
        .count       (fine_count),
        .count_valid (fine_count_valid),
        .peak_valid  (fine_peak_valid),
        .peak_pixel  (fine_peak_pixel),
        .peak_bin    (fine_peak_bin)
    );

endmodule

`default_nettype wire

/* test/hist_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_consts.svh"

module hist_tb;

    import hist_pkg::*;

    localparam int HITS = `DATA_NUM * `PIXEL_NUM * `ACQ_NUM;
    localparam int NPIX = `PIXEL_NUM;
    localparam int ROWS = 5;
    localparam int WAIT_MAX = 40;

    logic clk;
    logic combin_res;
    logic start;
    logic hit;
    coarse_bin_t coarse_bin;
    fine_bin_t fine_bin;
    logic accept;
    logic his_num;
    logic frame_done;
    logic coarse_peak_valid;
    pixel_t coarse_peak_pixel;
    coarse_bin_t coarse_peak_bin;
    logic fine_peak_valid;
    pixel_t fine_peak_pixel;
    fine_bin_t fine_peak_bin;

    // frame table, one nibble per hit, hit 0 in the low nibble
    int row_delay [ROWS];
    logic [4*HITS-1:0] row_coarse [ROWS];
    logic [4*HITS-1:0] row_fine [ROWS];
    logic [4*HITS-1:0] row_gap [ROWS];
    logic row_stray [ROWS];
    logic row_mid_start [ROWS];

    // model peaks per pixel
    coarse_bin_t exp_coarse [NPIX];
    fine_bin_t exp_fine [NPIX];

    // reports seen at the outputs
    pixel_t got_cpix [$];
    coarse_bin_t got_cbin [$];
    pixel_t got_fpix [$];
    fine_bin_t got_fbin [$];

    int done_cnt;
    int err_cnt;
    logic exp_bank;
    integer seed;

    hist_top i_dut (
        .clk               (clk),
        .combin_res        (combin_res),
        .start             (start),
        .hit               (hit),
        .coarse_bin        (coarse_bin),
        .fine_bin          (fine_bin),
        .accept            (accept),
        .his_num           (his_num),
        .frame_done        (frame_done),
        .coarse_peak_valid (coarse_peak_valid),
        .coarse_peak_pixel (coarse_peak_pixel),
        .coarse_peak_bin   (coarse_peak_bin),
        .fine_peak_valid   (fine_peak_valid),
        .fine_peak_pixel   (fine_peak_pixel),
        .fine_peak_bin     (fine_peak_bin)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // overall run limit
    initial begin
        #20000;
        $display("watchdog expired before the run finished");
        $display("Simulation failed");
        $fatal(1);
    end

    // outputs sampled away from the rising edge
    always @(negedge clk) begin
        if (coarse_peak_valid) begin
            got_cpix.push_back(coarse_peak_pixel);
            got_cbin.push_back(coarse_peak_bin);
        end
        if (fine_peak_valid) begin
            got_fpix.push_back(fine_peak_pixel);
            got_fbin.push_back(fine_peak_bin);
        end
        if (frame_done) begin
            done_cnt++;
        end
    end

    task automatic stop_on_error(input string what);
        err_cnt++;
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_coarse(input string name, input coarse_bin_t exp,
                                input coarse_bin_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    task automatic check_fine(input string name, input fine_bin_t exp, input fine_bin_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %0h actual %0h", name, exp, act));
        end
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_bank(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_on_error($sformatf("FAIL %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic load_table();
        int k;
        // every hit on one bin, no gaps
        row_delay[0] = 2;
        row_coarse[0] = {HITS{4'h5}};
        row_fine[0] = {HITS{4'h3}};
        row_gap[0] = '0;
        row_stray[0] = 1'b0;
        row_mid_start[0] = 1'b0;
        // two bins tied, first one reached wins
        row_delay[1] = 1;
        row_coarse[1] = {24{8'hBA}};
        row_fine[1] = {24{8'h07}};
        row_gap[1] = {12{16'h1000}};
        row_stray[1] = 1'b0;
        row_mid_start[1] = 1'b0;
        // mixed bins with gaps, strays and a start mid-frame
        row_delay[2] = 5;
        row_coarse[2] = 192'h3C3A3F1D_7E3B3C5A_9C3D2E3F_8C3A4B3C_6D3E7F3A_1C3B2D3E;
        row_fine[2] = 192'h52741630_61527304_27130546_70165243_35217460_14603725;
        row_gap[2] = 192'h01020010_00300100_20001002_01000200_00102001_03000010;
        row_stray[2] = 1'b1;
        row_mid_start[2] = 1'b1;
        // reuses the bins of row 1 in the same bank
        row_delay[3] = 0;
        row_coarse[3] = 192'h9ABA9BC9_A9B9CAB9_9A9BC99A_BA99CB9A_A99B9AC9_9BA9C9AB;
        row_fine[3] = 192'h07160701_17060710_60170716_01766017_71600716_06171706;
        row_gap[3] = '0;
        row_stray[3] = 1'b1;
        row_mid_start[3] = 1'b0;
        // random frame
        seed = 32'h9bea859e;
        row_delay[4] = 3;
        row_stray[4] = 1'b1;
        row_mid_start[4] = 1'b1;
        for (k = 0; k < HITS; k++) begin
            row_coarse[4][4*k +: 4] = 4'($random(seed));
            row_fine[4][4*k +: 4] = 4'($random(seed));
            row_gap[4][4*k +: 4] = 4'($unsigned($random(seed)) % 3);
        end
    endtask

    // peak is the bin whose count first went strictly above the running max
    task automatic compute_peaks(input int r);
        int cnt_c [NPIX][16];
        int cnt_f [NPIX][8];
        int max_c [NPIX];
        int max_f [NPIX];
        int k;
        int p;
        int c;
        int f;
        for (p = 0; p < NPIX; p++) begin
            max_c[p] = 0;
            max_f[p] = 0;
            for (c = 0; c < 16; c++) begin
                cnt_c[p][c] = 0;
            end
            for (f = 0; f < 8; f++) begin
                cnt_f[p][f] = 0;
            end
        end
        for (k = 0; k < HITS; k++) begin
            p = (k / `DATA_NUM) % NPIX;
            c = row_coarse[r][4*k +: 4];
            f = row_fine[r][4*k +: 3];
            cnt_c[p][c]++;
            cnt_f[p][f]++;
            if (cnt_c[p][c] > max_c[p]) begin
                max_c[p] = cnt_c[p][c];
                exp_coarse[p] = coarse_bin_t'(c);
            end
            if (cnt_f[p][f] > max_f[p]) begin
                max_f[p] = cnt_f[p][f];
                exp_fine[p] = fine_bin_t'(f);
            end
        end
    endtask

    task automatic run_frame(input int r);
        int k;
        int g;
        int n;
        got_cpix.delete();
        got_cbin.delete();
        got_fpix.delete();
        got_fbin.delete();
        done_cnt = 0;
        compute_peaks(r);
        // hits while idle, must be dropped
        if (row_stray[r]) begin
            for (k = 0; k < 3; k++) begin
                @(negedge clk);
                hit = 1'b1;
                coarse_bin = 4'hf;
                fine_bin = 3'h7;
            end
            @(negedge clk);
            hit = 1'b0;
        end
        repeat (row_delay[r]) @(negedge clk);
        check_bank($sformatf("row %0d bank before start", r), exp_bank, his_num);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        n = 0;
        while (!accept) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                stop_on_error("accept did not rise after start");
            end
        end
        for (k = 0; k < HITS; k++) begin
            for (g = 0; g < row_gap[r][4*k +: 4]; g++) begin
                hit = 1'b0;
                start = 1'b0;
                @(negedge clk);
            end
            hit = 1'b1;
            coarse_bin = row_coarse[r][4*k +: 4];
            fine_bin = row_fine[r][4*k +: 3];
            // start inside an open frame is ignored
            start = row_mid_start[r] && (k == 20);
            @(negedge clk);
        end
        hit = 1'b0;
        start = 1'b0;
        n = 0;
        while (!frame_done) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                stop_on_error("frame_done did not arrive after the last hit");
            end
        end
        check_flag($sformatf("row %0d accept at frame end", r), 1'b0, accept);
        // hit and start during the done cycle
        if (row_stray[r]) begin
            hit = 1'b1;
            start = 1'b1;
        end
        @(negedge clk);
        hit = 1'b0;
        start = 1'b0;
        n = 0;
        while (got_cbin.size() < NPIX || got_fbin.size() < NPIX) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) begin
                stop_on_error("peak reports missing after frame_done");
            end
        end
        repeat (2) @(negedge clk);
        check_count($sformatf("row %0d coarse reports", r), NPIX, got_cbin.size());
        check_count($sformatf("row %0d fine reports", r), NPIX, got_fbin.size());
        check_count($sformatf("row %0d frame_done pulses", r), 1, done_cnt);
        for (n = 0; n < NPIX; n++) begin
            check_pixel($sformatf("row %0d coarse pixel", r), pixel_t'(n), got_cpix[n]);
            check_coarse($sformatf("row %0d pixel %0d coarse peak", r, n),
                         exp_coarse[n], got_cbin[n]);
            check_pixel($sformatf("row %0d fine pixel", r), pixel_t'(n), got_fpix[n]);
            check_fine($sformatf("row %0d pixel %0d fine peak", r, n), exp_fine[n], got_fbin[n]);
        end
        exp_bank = ~exp_bank;
        check_bank($sformatf("row %0d bank after frame", r), exp_bank, his_num);
    endtask

    initial begin
        int r;
        combin_res = 1'b0;
        start = 1'b0;
        hit = 1'b0;
        coarse_bin = '0;
        fine_bin = '0;
        err_cnt = 0;
        done_cnt = 0;
        exp_bank = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
        // idle outputs after reset
        check_flag("accept after reset", 1'b0, accept);
        check_flag("frame_done after reset", 1'b0, frame_done);
        check_flag("coarse valid after reset", 1'b0, coarse_peak_valid);
        check_flag("fine valid after reset", 1'b0, fine_peak_valid);
        check_bank("bank after reset", 1'b0, his_num);
        for (r = 0; r < ROWS; r++) begin
            run_frame(r);
        end
        @(negedge clk);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* hist_builder.f */
+incdir+include
hdl/hist_pkg.sv
hdl/hist_fsm.sv
hdl/frame_counter.sv
hdl/bin_histogram.sv
hdl/peak_tracker.sv
hdl/hist_top.sv
test/hist_tb.sv
